// ==== hw/isp_video_pkg.sv ====
`default_nettype none

// video timing sizes shared by the line memories and counters
package isp_video_pkg;

	// pairs held by one line memory
	// 512 pairs give lines of up to 1024 pixels
	localparam int MAX_PAIRS = 512;

	// pair column counter
	// one bit wider than the memory address
	localparam int X_CNT_WIDTH = 10;

	// line counter inside a frame
	localparam int Y_CNT_WIDTH = 11;

	// chained line delays
	// stage 0 gives the centre row and stage 1 the top row
	localparam int N_LINE_DELAYS = 2;

endpackage

`default_nettype wire

// ==== hw/isp_bayer_pkg.sv ====
`default_nettype none

// bayer and rgb sample formats
package isp_bayer_pkg;

	// bits per raw or colour sample
	localparam int P_DEPTH = 10;

	// two samples per clock
	localparam int PW = 2 * P_DEPTH;

	// raw pair from the sensor
	// low half is the left pixel
	typedef logic [PW-1:0] raw_pair_t;

	// one colour channel for two pixels
	// same layout as the raw pair
	typedef logic [PW-1:0] rgb_pair_t;

endpackage

`default_nettype wire

// ==== hw/black_level.sv ====
`timescale 1ns/1ps
`default_nettype none

module black_level
	import isp_bayer_pkg::*;
(
	input  wire logic             i_pclk,
	input  wire logic             i_arstn,
	input  wire logic             i_vsync,
	input  wire logic             i_hsync,
	input  wire logic             i_de,
	input  wire raw_pair_t        i_raw,
	input  wire logic [P_DEPTH-1:0] i_black,
	output logic                  o_vsync,
	output logic                  o_hsync,
	output logic                  o_de,
	output raw_pair_t             o_raw
);

	// subtract the pedestal and stop at zero
	function automatic logic [P_DEPTH-1:0] sub_clamp(
		input logic [P_DEPTH-1:0] val,
		input logic [P_DEPTH-1:0] ped
	);
		logic [P_DEPTH:0] diff;
		diff = {1'b0, val} - {1'b0, ped};
		// borrow out means the sample sat below black
		return diff[P_DEPTH] ? '0 : diff[P_DEPTH-1:0];
	endfunction

	always_ff @(posedge i_pclk)
	begin
		if (!i_arstn)
		begin
			o_vsync <= 1'b0;
			o_hsync <= 1'b0;
			o_de    <= 1'b0;
			o_raw   <= '0;
		end
		else
		begin
			// syncs take the same single cycle as the data
			o_vsync <= i_vsync;
			o_hsync <= i_hsync;
			o_de    <= i_de;
			// blanking is forced to zero
			// the line memories then only ever hold clean pixels
			if (i_de)
			begin
				o_raw[P_DEPTH-1:0]  <= sub_clamp(i_raw[P_DEPTH-1:0], i_black);
				o_raw[PW-1:P_DEPTH] <= sub_clamp(i_raw[PW-1:P_DEPTH], i_black);
			end
			else
			begin
				o_raw <= '0;
			end
		end
	end

endmodule

`default_nettype wire

// ==== hw/line_delay.sv ====
`timescale 1ns/1ps
`default_nettype none

module line_delay
	import isp_bayer_pkg::*, isp_video_pkg::*;
(
	input  wire logic      i_pclk,
	input  wire logic      i_arstn,
	input  wire logic      i_de,
	input  wire raw_pair_t i_row,
	output raw_pair_t      o_row
);

	// address bits of the pair memory
	localparam int ADDR_W = $clog2(MAX_PAIRS);

	// one line of pairs
	raw_pair_t mem [MAX_PAIRS];

	// column of the pair now on i_row
	logic [X_CNT_WIDTH-1:0] r_col;
	logic [ADDR_W-1:0]      w_addr;

	assign w_addr = r_col[ADDR_W-1:0];

	// column restarts at every line
	// so the delay does not depend on the blanking length
	always_ff @(posedge i_pclk)
	begin
		if (!i_arstn)
		begin
			r_col <= '0;
		end
		else if (i_de)
		begin
			r_col <= r_col + 1'b1;
		end
		else
		begin
			r_col <= '0;
		end
	end

	// write the new pair where the old one is read
	always_ff @(posedge i_pclk)
	begin
		if (i_de)
		begin
			mem[w_addr] <= i_row;
		end
	end

	// read is combinational
	// the pair of the previous line at this column
	assign o_row = mem[w_addr];

endmodule

`default_nettype wire

// ==== hw/raw_to_rgb.sv ====
`timescale 1ns/1ps
`default_nettype none

module raw_to_rgb
	import isp_bayer_pkg::*, isp_video_pkg::*;
(
	input  wire logic             i_pclk,
	input  wire logic             i_arstn,
	input  wire logic             i_vsync,
	input  wire logic             i_hsync,
	input  wire logic             i_de,
	input  wire raw_pair_t        i_p_11,
	input  wire raw_pair_t        i_p_00,
	input  wire raw_pair_t        i_p_01,
	output logic                  o_vsync,
	output logic                  o_hsync,
	output logic                  o_de,
	output logic [X_CNT_WIDTH-1:0] o_cnt,
	output rgb_pair_t             o_r,
	output rgb_pair_t             o_g,
	output rgb_pair_t             o_b
);

	// half of a plus half of b
	function automatic logic [P_DEPTH-1:0] avg2(
		input logic [P_DEPTH-1:0] a,
		input logic [P_DEPTH-1:0] b
	);
		return (a >> 1) + (b >> 1);
	endfunction

	// average of two pair averages
	function automatic logic [P_DEPTH-1:0] avg4(
		input logic [P_DEPTH-1:0] a,
		input logic [P_DEPTH-1:0] b,
		input logic [P_DEPTH-1:0] c,
		input logic [P_DEPTH-1:0] d
	);
		return avg2(avg2(a, b), avg2(c, d));
	endfunction

	// counters and sync delays
	logic [X_CNT_WIDTH-1:0] r_x_cnt;
	logic [X_CNT_WIDTH-1:0] r_x_cnt_1p;
	logic [Y_CNT_WIDTH-1:0] r_y_cnt;
	logic r_vsync_1p;
	logic r_hsync_1p;
	logic r_de_1p;

	// right column straight from the inputs after row selection
	raw_pair_t w_r_11;
	raw_pair_t w_r_00;
	raw_pair_t w_r_01;

	// centre column one cycle old
	raw_pair_t r_c_11;
	raw_pair_t r_c_00;
	raw_pair_t r_c_01;

	// left column keeps only its right pixel
	// that pixel is the only one the 3x3 window touches
	logic [P_DEPTH-1:0] r_l_11;
	logic [P_DEPTH-1:0] r_l_00;
	logic [P_DEPTH-1:0] r_l_01;

	// window pixels
	// t m b for top centre bottom rows, l1 c0 c1 r0 for columns
	logic [P_DEPTH-1:0] t_l1, t_c0, t_c1, t_r0;
	logic [P_DEPTH-1:0] m_l1, m_c0, m_c1, m_r0;
	logic [P_DEPTH-1:0] b_l1, b_c0, b_c1, b_r0;

	// row selection at the frame top
	// blanking reads as zero so the last pair sees a black right neighbour
	always_comb
	begin
		w_r_01 = i_de ? i_p_01 : '0;
		if (!i_de)
		begin
			w_r_11 = '0;
			w_r_00 = '0;
		end
		else if (r_y_cnt == '0)
		begin
			// line 0 stands in for both rows above
			w_r_11 = i_p_01;
			w_r_00 = i_p_01;
		end
		else if (r_y_cnt == Y_CNT_WIDTH'(1))
		begin
			w_r_11 = i_p_00;
			w_r_00 = i_p_00;
		end
		else
		begin
			w_r_11 = i_p_11;
			w_r_00 = i_p_00;
		end
	end

	assign t_l1 = r_l_11;
	assign t_c0 = r_c_11[P_DEPTH-1:0];
	assign t_c1 = r_c_11[PW-1:P_DEPTH];
	assign t_r0 = w_r_11[P_DEPTH-1:0];
	assign m_l1 = r_l_00;
	assign m_c0 = r_c_00[P_DEPTH-1:0];
	assign m_c1 = r_c_00[PW-1:P_DEPTH];
	assign m_r0 = w_r_00[P_DEPTH-1:0];
	assign b_l1 = r_l_01;
	assign b_c0 = r_c_01[P_DEPTH-1:0];
	assign b_c1 = r_c_01[PW-1:P_DEPTH];
	assign b_r0 = w_r_01[P_DEPTH-1:0];

	// window shift
	// cleared in blanking so column 0 finds a zero left neighbour
	always_ff @(posedge i_pclk)
	begin
		if (i_de)
		begin
			r_c_11 <= w_r_11;
			r_c_00 <= w_r_00;
			r_c_01 <= w_r_01;
			r_l_11 <= t_c1;
			r_l_00 <= m_c1;
			r_l_01 <= b_c1;
		end
		else
		begin
			// last pair of the line still sits in the centre
			// it is consumed this cycle and may be dropped at the edge
			r_c_11 <= '0;
			r_c_00 <= '0;
			r_c_01 <= '0;
			r_l_11 <= '0;
			r_l_00 <= '0;
			r_l_01 <= '0;
		end
	end

	// counters and syncs
	always_ff @(posedge i_pclk)
	begin
		if (!i_arstn)
		begin
			r_x_cnt    <= '0;
			r_x_cnt_1p <= '0;
			o_cnt      <= '0;
			r_y_cnt    <= '0;
			r_vsync_1p <= 1'b0;
			r_hsync_1p <= 1'b0;
			r_de_1p    <= 1'b0;
			o_vsync    <= 1'b0;
			o_hsync    <= 1'b0;
			o_de       <= 1'b0;
		end
		else
		begin
			r_vsync_1p <= i_vsync;
			r_hsync_1p <= i_hsync;
			r_de_1p    <= i_de;
			o_vsync    <= r_vsync_1p;
			o_hsync    <= r_hsync_1p;
			o_de       <= r_de_1p;
			r_x_cnt_1p <= r_x_cnt;
			o_cnt      <= r_x_cnt_1p;
			if (i_de)
			begin
				r_x_cnt <= r_x_cnt + 1'b1;
			end
			else
			begin
				r_x_cnt <= '0;
			end
			// frame start wins over line end
			if (!i_vsync && r_vsync_1p)
			begin
				r_y_cnt <= '0;
			end
			else if (!i_de && r_de_1p)
			begin
				r_y_cnt <= r_y_cnt + 1'b1;
			end
		end
	end

	// interpolation of the centre pair
	always_ff @(posedge i_pclk)
	begin
		if (!i_arstn)
		begin
			o_r <= '0;
			o_g <= '0;
			o_b <= '0;
		end
		else if (!r_de_1p)
		begin
			o_r <= '0;
			o_g <= '0;
			o_b <= '0;
		end
		else if (!r_y_cnt[0])
		begin
			// even line G R
			// left pixel is G with R beside it and B above and below
			o_r[P_DEPTH-1:0] <= avg2(m_l1, m_c1);
			o_g[P_DEPTH-1:0] <= m_c0;
			o_b[P_DEPTH-1:0] <= avg2(t_c0, b_c0);
			// right pixel is R with B on the diagonals
			o_r[PW-1:P_DEPTH] <= m_c1;
			o_g[PW-1:P_DEPTH] <= avg4(m_r0, m_c0, t_c1, b_c1);
			o_b[PW-1:P_DEPTH] <= avg4(t_r0, b_c0, b_r0, t_c0);
		end
		else
		begin
			// odd line B G
			// left pixel is B with R on the diagonals
			o_r[P_DEPTH-1:0] <= avg4(t_c1, b_l1, b_c1, t_l1);
			o_g[P_DEPTH-1:0] <= avg4(t_c0, b_c0, m_c1, m_l1);
			o_b[P_DEPTH-1:0] <= m_c0;
			// right pixel is G with R above and below and B beside it
			o_r[PW-1:P_DEPTH] <= avg2(t_c1, b_c1);
			o_g[PW-1:P_DEPTH] <= m_c1;
			o_b[PW-1:P_DEPTH] <= avg2(m_r0, m_c0);
		end
	end

endmodule

`default_nettype wire

// ==== hw/isp_frontend_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module isp_frontend_top
	import isp_bayer_pkg::*, isp_video_pkg::*;
(
	input  wire logic             i_pclk,
	input  wire logic             i_arstn,
	input  wire logic             i_vsync,
	input  wire logic             i_hsync,
	input  wire logic             i_de,
	input  wire raw_pair_t        i_raw,
	input  wire logic [P_DEPTH-1:0] i_black,
	output logic                  o_vsync,
	output logic                  o_hsync,
	output logic                  o_de,
	output logic [X_CNT_WIDTH-1:0] o_cnt,
	output rgb_pair_t             o_r,
	output rgb_pair_t             o_g,
	output rgb_pair_t             o_b
);

	// black level corrected stream
	logic      blc_vsync;
	logic      blc_hsync;
	logic      blc_de;
	raw_pair_t blc_data;

	// entry k is the line k lines before the current one
	raw_pair_t row_chain [N_LINE_DELAYS+1];

	black_level u_black_level (
		.i_pclk  (i_pclk),
		.i_arstn (i_arstn),
		.i_vsync (i_vsync),
		.i_hsync (i_hsync),
		.i_de    (i_de),
		.i_raw   (i_raw),
		.i_black (i_black),
		.o_vsync (blc_vsync),
		.o_hsync (blc_hsync),
		.o_de    (blc_de),
		.o_raw   (blc_data)
	);

	assign row_chain[0] = blc_data;

	// every stage writes with the same de
	for (genvar k = 0; k < N_LINE_DELAYS; k++)
	begin : g_line
		line_delay u_line_delay (
			.i_pclk  (i_pclk),
			.i_arstn (i_arstn),
			.i_de    (blc_de),
			.i_row   (row_chain[k]),
			.o_row   (row_chain[k+1])
		);
	end

	// bottom row is the live line
	raw_to_rgb u_raw_to_rgb (
		.i_pclk  (i_pclk),
		.i_arstn (i_arstn),
		.i_vsync (blc_vsync),
		.i_hsync (blc_hsync),
		.i_de    (blc_de),
		.i_p_11  (row_chain[N_LINE_DELAYS]),
		.i_p_00  (row_chain[1]),
		.i_p_01  (row_chain[0]),
		.o_vsync (o_vsync),
		.o_hsync (o_hsync),
		.o_de    (o_de),
		.o_cnt   (o_cnt),
		.o_r     (o_r),
		.o_g     (o_g),
		.o_b     (o_b)
	);

endmodule

`default_nettype wire

// ==== verification/isp_checker.sv ====
`timescale 1ns/1ps
`default_nettype none

module isp_checker
	import isp_bayer_pkg::*, isp_video_pkg::*;
#(
	parameter int FRAME_PAIRS = 8,
	parameter int FRAME_LINES = 6,
	parameter int STALL_LIMIT = 16
)
(
	input  wire logic                   i_pclk,
	input  wire logic                   i_arstn,
	input  wire logic [7:0]             i_test,
	input  wire logic                   i_vsync,
	input  wire logic                   i_hsync,
	input  wire logic                   i_de,
	input  wire raw_pair_t              i_raw,
	input  wire logic [P_DEPTH-1:0]     i_black,
	input  wire logic                   i_out_vsync,
	input  wire logic                   i_out_hsync,
	input  wire logic                   i_out_de,
	input  wire logic [X_CNT_WIDTH-1:0] i_out_cnt,
	input  wire rgb_pair_t              i_out_r,
	input  wire rgb_pair_t              i_out_g,
	input  wire rgb_pair_t              i_out_b,
	output int                          o_errors,
	output int                          o_pairs
);

	// black corrected input frame, one sample per pixel
	logic [P_DEPTH-1:0] img [FRAME_LINES][2*FRAME_PAIRS];
	int in_y = 0;
	int in_x = 0;
	int out_y = 0;
	int out_x = 0;
	int in_pairs = 0;
	int err_cnt = 0;
	int pair_cnt = 0;
	int stall = 0;
	int cur_test = 0;
	int test_checks = 0;
	int test_errors = 0;
	logic prev_in_vs = 1'b0;
	logic prev_in_de = 1'b0;
	logic prev_out_vs = 1'b0;
	logic prev_out_de = 1'b0;
	// input syncs of the last three cycles, bit 2 is the oldest
	logic [2:0] vs_h = '0;
	logic [2:0] hs_h = '0;
	logic [2:0] de_h = '0;
	logic [3*PW-1:0] exp_rgb;

	assign o_errors = err_cnt;
	assign o_pairs  = pair_cnt;

	function automatic logic [P_DEPTH-1:0] below_black(
		input logic [P_DEPTH-1:0] val,
		input logic [P_DEPTH-1:0] black
	);
		// samples under the pedestal become black
		return (val > black) ? val - black : '0;
	endfunction

	function automatic logic [P_DEPTH-1:0] half_sum(
		input logic [P_DEPTH-1:0] a,
		input logic [P_DEPTH-1:0] b
	);
		return (a >> 1) + (b >> 1);
	endfunction

	// pixels outside the line read as zero
	function automatic logic [P_DEPTH-1:0] pix(input int line, input int px);
		if (px < 0 || px >= 2 * FRAME_PAIRS)
		begin
			return '0;
		end
		return img[line][px];
	endfunction

	// expected {r, g, b} for pair x of output line y
	function automatic logic [3*PW-1:0] ref_pair(input int y, input int x);
		int top;
		int mid;
		int px;
		int h;
		logic [P_DEPTH-1:0] c;
		logic [P_DEPTH-1:0] horiz;
		logic [P_DEPTH-1:0] vert;
		logic [P_DEPTH-1:0] cross_avg;
		logic [P_DEPTH-1:0] diag;
		rgb_pair_t r;
		rgb_pair_t g;
		rgb_pair_t b;
		// rows above line 0 repeat line 0, bottom row is line y itself
		mid = (y == 0) ? 0 : y - 1;
		top = (y < 2) ? 0 : y - 2;
		for (h = 0; h < 2; h++)
		begin
			px = 2 * x + h;
			c = pix(mid, px);
			horiz = half_sum(pix(mid, px - 1), pix(mid, px + 1));
			vert = half_sum(pix(top, px), pix(y, px));
			cross_avg = half_sum(horiz, vert);
			diag = half_sum(half_sum(pix(top, px - 1), pix(y, px + 1)),
				half_sum(pix(top, px + 1), pix(y, px - 1)));
			if (y % 2 == 0)
			begin
				// G R line
				r[h*P_DEPTH +: P_DEPTH] = (h == 0) ? horiz : c;
				g[h*P_DEPTH +: P_DEPTH] = (h == 0) ? c : cross_avg;
				b[h*P_DEPTH +: P_DEPTH] = (h == 0) ? vert : diag;
			end
			else
			begin
				// B G line
				r[h*P_DEPTH +: P_DEPTH] = (h == 0) ? diag : vert;
				g[h*P_DEPTH +: P_DEPTH] = (h == 0) ? cross_avg : c;
				b[h*P_DEPTH +: P_DEPTH] = (h == 0) ? c : horiz;
			end
		end
		return {r, g, b};
	endfunction

	function automatic string test_name(input int id);
		case (id)
			1: return "idle after reset";
			2: return "random frames, no pedestal";
			3: return "pedestal 64 with clamp";
			4: return "sync latency and column count";
			5: return "two frames, different blanking";
			default: return "unnamed";
		endcase
	endfunction

	task automatic check_value(
		input string name,
		input logic [PW-1:0] expected,
		input logic [PW-1:0] actual
	);
		test_checks++;
		if (actual !== expected)
		begin
			$display("[ERROR] t=%0t %s expected %h got %h", $time, name, expected, actual);
			err_cnt++;
			test_errors++;
		end
	endtask

	// everything is sampled mid cycle, where inputs and outputs are settled
	always @(negedge i_pclk)
	begin
		if (i_test != cur_test)
		begin
			if (cur_test != 0)
			begin
				$display("test %0d (%s): %0d checks, %0d errors",
					cur_test, test_name(cur_test), test_checks, test_errors);
			end
			cur_test = i_test;
			test_checks = 0;
			test_errors = 0;
		end
		if (i_arstn)
		begin
			// syncs come out three cycles late
			check_value("o_vsync", vs_h[2], i_out_vsync);
			check_value("o_hsync", hs_h[2], i_out_hsync);
			check_value("o_de", de_h[2], i_out_de);
			if (!i_out_de)
			begin
				check_value("o_r", '0, i_out_r);
				check_value("o_g", '0, i_out_g);
				check_value("o_b", '0, i_out_b);
			end
			// input frame, frame start wins over line end
			if (!i_vsync && prev_in_vs)
			begin
				in_y = 0;
				in_x = 0;
			end
			else if (!i_de && prev_in_de)
			begin
				in_y++;
				in_x = 0;
			end
			if (i_de)
			begin
				if (in_y < FRAME_LINES && in_x < FRAME_PAIRS)
				begin
					img[in_y][2*in_x] = below_black(i_raw[P_DEPTH-1:0], i_black);
					img[in_y][2*in_x+1] = below_black(i_raw[PW-1:P_DEPTH], i_black);
				end
				in_x++;
				in_pairs++;
			end
			// output side counts its own lines and pairs
			if (!i_out_vsync && prev_out_vs)
			begin
				out_y = 0;
				out_x = 0;
			end
			else if (!i_out_de && prev_out_de)
			begin
				out_y++;
				out_x = 0;
			end
			if (i_out_de)
			begin
				if (out_y >= FRAME_LINES || out_x >= FRAME_PAIRS)
				begin
					$display("t=%0t output pair lies outside the frame at line %0d pair %0d",
						$time, out_y, out_x);
					err_cnt++;
					test_errors++;
				end
				else
				begin
					exp_rgb = ref_pair(out_y, out_x);
					check_value("o_cnt", PW'(out_x), PW'(i_out_cnt));
					check_value("o_r", exp_rgb[3*PW-1:2*PW], i_out_r);
					check_value("o_g", exp_rgb[2*PW-1:PW], i_out_g);
					check_value("o_b", exp_rgb[PW-1:0], i_out_b);
				end
				out_x++;
				pair_cnt++;
				stall = 0;
			end
			else if (in_pairs > pair_cnt)
			begin
				// pairs went in but nothing comes out
				stall++;
				if (stall > STALL_LIMIT)
				begin
					$display("t=%0t no output pair arrived within %0d cycles",
						$time, STALL_LIMIT);
					err_cnt++;
					test_errors++;
					stall = 0;
				end
			end
		end
		prev_in_vs = i_vsync;
		prev_in_de = i_de;
		prev_out_vs = i_out_vsync;
		prev_out_de = i_out_de;
		vs_h = {vs_h[1:0], i_vsync};
		hs_h = {hs_h[1:0], i_hsync};
		de_h = {de_h[1:0], i_de};
	end

endmodule

`default_nettype wire

// ==== verification/tb_isp_frontend.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_isp_frontend
	import isp_bayer_pkg::*, isp_video_pkg::*;
();

	localparam int FRAME_PAIRS = 8;
	localparam int FRAME_LINES = 6;
	localparam int CLK_PERIOD = 8;
	localparam int RESET_CYCLES = 5;
	localparam int DRAIN_LIMIT = 200;

	logic pclk;
	logic arstn;
	logic vsync;
	logic hsync;
	logic de;
	raw_pair_t raw;
	logic [P_DEPTH-1:0] black;
	logic out_vsync;
	logic out_hsync;
	logic out_de;
	logic [X_CNT_WIDTH-1:0] out_cnt;
	rgb_pair_t out_r;
	rgb_pair_t out_g;
	rgb_pair_t out_b;
	logic [7:0] test_id;
	logic [31:0] lfsr = 32'h3cae_cd25;
	int sent_pairs;
	int errors;
	int pairs;

	isp_frontend_top uut (
		.i_pclk (pclk), .i_arstn (arstn),
		.i_vsync (vsync), .i_hsync (hsync), .i_de (de),
		.i_raw (raw), .i_black (black),
		.o_vsync (out_vsync), .o_hsync (out_hsync), .o_de (out_de),
		.o_cnt (out_cnt), .o_r (out_r), .o_g (out_g), .o_b (out_b)
	);

	isp_checker #(
		.FRAME_PAIRS (FRAME_PAIRS),
		.FRAME_LINES (FRAME_LINES)
	) u_checker (
		.i_pclk (pclk), .i_arstn (arstn), .i_test (test_id),
		.i_vsync (vsync), .i_hsync (hsync), .i_de (de),
		.i_raw (raw), .i_black (black),
		.i_out_vsync (out_vsync), .i_out_hsync (out_hsync), .i_out_de (out_de),
		.i_out_cnt (out_cnt), .i_out_r (out_r), .i_out_g (out_g), .i_out_b (out_b),
		.o_errors (errors), .o_pairs (pairs)
	);

	initial
	begin
		pclk = 1'b0;
		forever #(CLK_PERIOD / 2) pclk = ~pclk;
	end

	// taps 32 22 2 1
	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		logic fb;
		fb = s[31] ^ s[21] ^ s[1] ^ s[0];
		return {s[30:0], fb};
	endfunction

	// one lfsr step per bit, so n bits cost n steps
	task automatic take_bits(input int n, output logic [P_DEPTH-1:0] val);
		val = '0;
		for (int i = 0; i < n; i++)
		begin
			lfsr = lfsr_step(lfsr);
			val = {val[P_DEPTH-2:0], lfsr[0]};
		end
	endtask

	// hold the values for one cycle, starting just after the rising edge
	task automatic drive(input logic vs, input logic hs, input logic en, input raw_pair_t data);
		vsync = vs;
		hsync = hs;
		de = en;
		raw = data;
		@(posedge pclk);
		#1;
	endtask

	// idle line with vsync, then lines of random pairs
	task automatic send_frame(input int blank, input int bits);
		logic [P_DEPTH-1:0] lo;
		logic [P_DEPTH-1:0] hi;
		for (int i = 0; i < FRAME_PAIRS + blank; i++)
		begin
			drive(i < 3, 1'b0, 1'b0, '0);
		end
		for (int y = 0; y < FRAME_LINES; y++)
		begin
			for (int x = 0; x < FRAME_PAIRS; x++)
			begin
				take_bits(bits, lo);
				take_bits(bits, hi);
				drive(1'b0, 1'b0, 1'b1, {hi, lo});
				sent_pairs++;
			end
			// hsync marks the start of the blanking
			for (int b = 0; b < blank; b++)
			begin
				drive(1'b0, b < 2, 1'b0, '0);
			end
		end
	endtask

	task automatic wait_drain();
		int n;
		n = 0;
		while (pairs != sent_pairs && n < DRAIN_LIMIT)
		begin
			drive(1'b0, 1'b0, 1'b0, '0);
			n++;
		end
		if (pairs != sent_pairs)
		begin
			$display("timeout: only %0d of %0d output pairs arrived", pairs, sent_pairs);
			$display("Something failed");
			$finish;
		end
	endtask

	initial
	begin
		arstn = 1'b0;
		vsync = 1'b0;
		hsync = 1'b0;
		de = 1'b0;
		raw = '0;
		black = '0;
		test_id = '0;
		sent_pairs = 0;
		repeat (RESET_CYCLES) @(posedge pclk);
		#1;
		arstn = 1'b1;
		test_id = 8'd1;
		repeat (20) drive(1'b0, 1'b0, 1'b0, '0);
		test_id = 8'd2;
		send_frame(6, P_DEPTH);
		send_frame(6, P_DEPTH);
		wait_drain();
		// 8 bit samples put about a quarter of them under the pedestal
		test_id = 8'd3;
		black = P_DEPTH'(64);
		send_frame(6, 8);
		wait_drain();
		test_id = 8'd4;
		black = '0;
		send_frame(4, P_DEPTH);
		wait_drain();
		test_id = 8'd5;
		send_frame(6, P_DEPTH);
		send_frame(13, P_DEPTH);
		wait_drain();
		test_id = '0;
		repeat (2) drive(1'b0, 1'b0, 1'b0, '0);
		$display("summary: %0d output pairs compared, %0d errors", pairs, errors);
		if (errors == 0)
		begin
			$display("Everything OK");
		end
		else
		begin
			$display("Something failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

// ==== src.f ====
hw/isp_video_pkg.sv
hw/isp_bayer_pkg.sv
hw/black_level.sv
hw/line_delay.sv
hw/raw_to_rgb.sv
hw/isp_frontend_top.sv
verification/isp_checker.sv
verification/tb_isp_frontend.sv

// ==== Bender.yml ====
package:
  name: isp_frontend

sources:
  - hw/isp_video_pkg.sv
  - hw/isp_bayer_pkg.sv
  - hw/black_level.sv
  - hw/line_delay.sv
  - hw/raw_to_rgb.sv
  - hw/isp_frontend_top.sv
  - target: test
    files:
      - verification/isp_checker.sv
      - verification/tb_isp_frontend.sv
